// File: local_credits_host_wr.f
+incdir+verilog
verilog/host_wr_req_pkg.sv
verilog/host_wr_axis_pkg.sv
verilog/sync_fifo.sv
verilog/dest_req_mux.sv
verilog/dest_wr_queue.sv
verilog/dest_req_arb.sv
verilog/axis_mux_wr.sv
verilog/local_credits_host_wr.sv
verification/tb_local_credits_host_wr.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_local_credits_host_wr
FILELIST  ?= local_credits_host_wr.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF -- '$(PASS_MSG)' $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verification/tb_local_credits_host_wr.sv
/*
 * Testbench for the local-credit host write path.
 * Stimulus table, random output back-pressure, request and beat
 * scoreboards, compare tasks and a watchdog.
 */

`timescale 1ns/1ps
`default_nettype none

`include "credit_defs.svh"

module tb_local_credits_host_wr;

  import host_wr_req_pkg::*;
  import host_wr_axis_pkg::*;

  localparam int ROWS        = 12;
  localparam int WATCHDOG_NS = ROWS * (`MAX_LEN + 30) * 10 * 4;

  typedef struct packed {
    dest_t       dest;
    len_t        len;
    logic [31:0] vaddr;
    logic [7:0]  gap;
  } row_t;

  // Each row is one request. The gap holds its data back for that many cycles.
  // Row 0 withholds its data for 30 cycles, so its m_req must wait for it.
  localparam row_t stim_table [ROWS] = '{
    '{2'd2, 4'd5, 32'h2000_0000, 8'd30},
    '{2'd0, 4'd1, 32'h0000_0040, 8'd0},
    '{2'd1, 4'd8, 32'h1000_0100, 8'd2},
    '{2'd3, 4'd3, 32'h3000_0000, 8'd0},
    '{2'd0, 4'd4, 32'h0000_0080, 8'd1},
    '{2'd1, 4'd2, 32'h1000_0200, 8'd0},
    '{2'd2, 4'd8, 32'h2000_0400, 8'd3},
    '{2'd3, 4'd7, 32'h3000_0100, 8'd0},
    '{2'd0, 4'd6, 32'h0000_0100, 8'd5},
    '{2'd2, 4'd1, 32'h2000_0800, 8'd0},
    '{2'd1, 4'd3, 32'h1000_0300, 8'd0},
    '{2'd3, 4'd8, 32'h3000_0200, 8'd4}
  };

  logic                aclk = 1'b0;
  logic                arst_n = 1'b0;
  logic                s_req_valid = 1'b0;
  logic                s_req_ready;
  req_t                s_req = '0;
  logic [`N_DESTS-1:0] s_axis_valid = '0;
  logic [`N_DESTS-1:0] s_axis_ready;
  axis_beat_t          s_axis [`N_DESTS] = '{default: '0};
  logic                m_req_valid;
  logic                m_req_ready = 1'b0;
  req_t                m_req;
  logic                m_axis_valid;
  logic                m_axis_ready = 1'b0;
  axis_beat_t          m_axis;

  // Scoreboards. Requests are expected per destination, beats in issue order.
  int         exp_rows [`N_DESTS][$];
  axis_beat_t exp_beats [$];
  // Source side state of each destination's data stream.
  int         pend [`N_DESTS][$];
  int         cur_row [`N_DESTS];
  int         beat_k [`N_DESTS];
  int         gap_left [`N_DESTS];
  bit         busy [`N_DESTS];
  int         seq [ROWS];
  int         seq_cnt [`N_DESTS];
  bit         data_sent [ROWS];
  int         next_row = 0;
  int         req_row = 0;
  int         total_beats = 0;
  int         reqs_seen = 0;
  int         beats_seen = 0;
  int         err_value = 0;
  int         err_other = 0;
  int         seed = 97;
  bit         stim_en = 1'b0;
  bit         req_logged = 1'b0;

  local_credits_host_wr i_local_credits_host_wr (
    .aclk         (aclk),
    .arst_n       (arst_n),
    .s_req_valid  (s_req_valid),
    .s_req_ready  (s_req_ready),
    .s_req        (s_req),
    .s_axis_valid (s_axis_valid),
    .s_axis_ready (s_axis_ready),
    .s_axis       (s_axis),
    .m_req_valid  (m_req_valid),
    .m_req_ready  (m_req_ready),
    .m_req        (m_req),
    .m_axis_valid (m_axis_valid),
    .m_axis_ready (m_axis_ready),
    .m_axis       (m_axis)
  );

  always #5 aclk = ~aclk;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Expected values and compares.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Beat k of a request carries its destination, per-destination sequence and k.
  function automatic axis_beat_t make_beat(input int dest, input int sq, input int k,
                                           input int len);
    axis_beat_t b;
    b.data = data_t'({8'hA5, 8'(dest), 8'(sq), 8'(k), 32'h600D_0000 + 32'(k)});
    b.keep = '1;
    b.last = (k == len);
    return b;
  endfunction

  function automatic req_t row_req(input int r);
    req_t q;
    q.dest  = stim_table[r].dest;
    q.len   = stim_table[r].len;
    q.vaddr = stim_table[r].vaddr;
    return q;
  endfunction

  task automatic check_req(input string name, input req_t exp, input req_t got);
    if (got !== exp) begin
      err_value++;
      $display("FAILED %s exp %h got %h", name, exp, got);
    end
  endtask

  task automatic check_beat(input string name, input axis_beat_t exp, input axis_beat_t got);
    if (got !== exp) begin
      err_value++;
      $display("FAILED %s exp %h got %h", name, exp, got);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic got);
    if (got !== exp) begin
      err_value++;
      $display("FAILED %s exp %h got %h", name, exp, got);
    end
  endtask

  task automatic check_readies(input string name, input logic [`N_DESTS-1:0] exp,
                               input logic [`N_DESTS-1:0] got);
    if (got !== exp) begin
      err_value++;
      $display("FAILED %s exp %h got %h", name, exp, got);
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stimulus, one step per rising edge.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // A taken request hands its row to the data source and to the scoreboard.
  task automatic drive_requests();
    if (s_req_valid && s_req_ready) begin
      pend[stim_table[req_row].dest].push_back(req_row);
      exp_rows[stim_table[req_row].dest].push_back(req_row);
    end
    if (!s_req_valid || s_req_ready) begin
      if (next_row < ROWS) begin
        req_row = next_row;
        next_row++;
        s_req_valid <= 1'b1;
        s_req       <= row_req(req_row);
      end else begin
        s_req_valid <= 1'b0;
      end
    end
  endtask

  task automatic drive_data(input int d);
    if (s_axis_valid[d] && s_axis_ready[d]) begin
      if (beat_k[d] == int'(stim_table[cur_row[d]].len)) begin
        data_sent[cur_row[d]] = 1'b1;
        busy[d] = 1'b0;
      end else begin
        beat_k[d]++;
      end
    end
    if (!busy[d] && pend[d].size() > 0) begin
      cur_row[d]  = pend[d].pop_front();
      gap_left[d] = int'(stim_table[cur_row[d]].gap);
      beat_k[d]   = 1;
      busy[d]     = 1'b1;
    end
    // The payload only moves on after a transfer, so valid never drops mid-request.
    if (busy[d] && gap_left[d] > 0) begin
      gap_left[d]--;
      s_axis_valid[d] <= 1'b0;
    end else if (busy[d]) begin
      s_axis_valid[d] <= 1'b1;
      s_axis[d] <= make_beat(d, seq[cur_row[d]], beat_k[d],
                             int'(stim_table[cur_row[d]].len));
    end else begin
      s_axis_valid[d] <= 1'b0;
    end
  endtask

  always @(posedge aclk) begin
    if (stim_en) begin
      drive_requests();
      for (int d = 0; d < `N_DESTS; d++) begin
        drive_data(d);
      end
      m_req_ready  <= (($random(seed) & 3) != 0);
      m_axis_ready <= (($random(seed) & 3) != 0);
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Output monitor.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // A request is logged when it first shows, so beats that leave before it is taken still match.
  task automatic log_request();
    int r;
    if (exp_rows[m_req.dest].size() == 0) begin
      err_other++;
      $display("Unexpected m_req for destination %0d at %0t", m_req.dest, $time);
    end else begin
      r = exp_rows[m_req.dest].pop_front();
      check_req("m_req", row_req(r), m_req);
      if (!data_sent[r]) begin
        err_other++;
        $display("Request of row %0d was issued before all its data was sent", r);
      end
      for (int k = 1; k <= int'(stim_table[r].len); k++) begin
        exp_beats.push_back(make_beat(int'(stim_table[r].dest), seq[r], k,
                                      int'(stim_table[r].len)));
      end
      reqs_seen++;
    end
  endtask

  task automatic take_beat();
    if (exp_beats.size() == 0) begin
      err_other++;
      $display("A beat left on m_axis with no issued request waiting for it");
    end else begin
      check_beat("m_axis", exp_beats.pop_front(), m_axis);
      beats_seen++;
    end
  endtask

  // Falling edge sampling sees settled outputs and the readies of the coming edge.
  always @(negedge aclk) begin
    if (arst_n) begin
      if (m_req_valid && !req_logged) begin
        log_request();
        req_logged = 1'b1;
      end
      if (m_req_valid && m_req_ready) begin
        req_logged = 1'b0;
      end
      if (m_axis_valid && m_axis_ready) begin
        take_beat();
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Test sequence.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial begin
    for (int r = 0; r < ROWS; r++) begin
      seq[r] = seq_cnt[stim_table[r].dest];
      seq_cnt[stim_table[r].dest]++;
      total_beats += int'(stim_table[r].len);
    end
    repeat (16) @(posedge aclk);
    arst_n <= 1'b1;
    @(negedge aclk);
    // Idle state straight after reset.
    check_bit("m_req_valid", 1'b0, m_req_valid);
    check_bit("m_axis_valid", 1'b0, m_axis_valid);
    check_bit("s_req_ready", 1'b1, s_req_ready);
    check_readies("s_axis_ready", '1, s_axis_ready);
    @(posedge aclk);
    stim_en <= 1'b1;
    while (reqs_seen < ROWS || beats_seen < total_beats) begin
      @(posedge aclk);
    end
    // Quiet tail so that a stray extra request or beat is still caught.
    repeat (20) @(posedge aclk);
    for (int d = 0; d < `N_DESTS; d++) begin
      if (exp_rows[d].size() != 0) begin
        err_other++;
        $display("Destination %0d still expects %0d requests", d, exp_rows[d].size());
      end
    end
    if (exp_beats.size() != 0) begin
      err_other++;
      $display("%0d expected beats never left on m_axis", exp_beats.size());
    end
    $display("Errors: %0d value mismatches, %0d other failures", err_value, err_other);
    if (err_value + err_other == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: traffic did not complete within %0d ns", WATCHDOG_NS);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/local_credits_host_wr.sv
/*
 * Top level of the local-credit host write path.
 * Router, per-destination queues, arbiter and output stream multiplexer.
 */

`timescale 1ns/1ps
`default_nettype none

`include "credit_defs.svh"

module local_credits_host_wr (
  input  logic                         aclk,
  input  logic                         arst_n,
  input  logic                         s_req_valid,
  output logic                         s_req_ready,
  input  host_wr_req_pkg::req_t        s_req,
  input  logic [`N_DESTS-1:0]          s_axis_valid,
  output logic [`N_DESTS-1:0]          s_axis_ready,
  input  host_wr_axis_pkg::axis_beat_t s_axis [`N_DESTS],
  output logic                         m_req_valid,
  input  logic                         m_req_ready,
  output host_wr_req_pkg::req_t        m_req,
  output logic                         m_axis_valid,
  input  logic                         m_axis_ready,
  output host_wr_axis_pkg::axis_beat_t m_axis
);

  import host_wr_req_pkg::*;
  import host_wr_axis_pkg::*;

  // Router to queues.
  logic [`N_DESTS-1:0] q_valid;
  logic [`N_DESTS-1:0] q_ready;
  req_t                q_req;
  // Queues to arbiter.
  logic [`N_DESTS-1:0] cred_valid;
  logic [`N_DESTS-1:0] cred_ready;
  req_t                cred_req [`N_DESTS];
  // Queues to stream multiplexer.
  logic [`N_DESTS-1:0] d_valid;
  logic [`N_DESTS-1:0] d_ready;
  axis_beat_t          d_beat [`N_DESTS];
  // Arbiter to stream multiplexer.
  logic                ord_valid;
  logic                ord_ready;
  mux_user_t           ord;

  dest_req_mux inst_mux (
    .aclk        (aclk),
    .arst_n      (arst_n),
    .s_req_valid (s_req_valid),
    .s_req_ready (s_req_ready),
    .s_req       (s_req),
    .q_valid     (q_valid),
    .q_ready     (q_ready),
    .q_req       (q_req)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // One queue per destination.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  for (genvar i = 0; i < `N_DESTS; i++) begin : g_dest
    dest_wr_queue inst_queue (
      .aclk         (aclk),
      .arst_n       (arst_n),
      .s_req_valid  (q_valid[i]),
      .s_req_ready  (q_ready[i]),
      .s_req        (q_req),
      .s_axis_valid (s_axis_valid[i]),
      .s_axis_ready (s_axis_ready[i]),
      .s_axis       (s_axis[i]),
      .cred_valid   (cred_valid[i]),
      .cred_ready   (cred_ready[i]),
      .cred_req     (cred_req[i]),
      .d_valid      (d_valid[i]),
      .d_ready      (d_ready[i]),
      .d_beat       (d_beat[i])
    );
  end

  dest_req_arb inst_arb (
    .aclk        (aclk),
    .arst_n      (arst_n),
    .cred_valid  (cred_valid),
    .cred_ready  (cred_ready),
    .cred_req    (cred_req),
    .m_req_valid (m_req_valid),
    .m_req_ready (m_req_ready),
    .m_req       (m_req),
    .ord_valid   (ord_valid),
    .ord_ready   (ord_ready),
    .ord         (ord)
  );

  axis_mux_wr inst_mux_wr (
    .aclk         (aclk),
    .arst_n       (arst_n),
    .ord_valid    (ord_valid),
    .ord_ready    (ord_ready),
    .ord          (ord),
    .d_valid      (d_valid),
    .d_ready      (d_ready),
    .d_beat       (d_beat),
    .m_axis_valid (m_axis_valid),
    .m_axis_ready (m_axis_ready),
    .m_axis       (m_axis)
  );

endmodule

`default_nettype wire

// File: verilog/axis_mux_wr.sv
/*
 * Output stream multiplexer.
 * Follows the issue-order queue and drains each request's beats in turn.
 */

`timescale 1ns/1ps
`default_nettype none

`include "credit_defs.svh"

module axis_mux_wr (
  input  logic                         aclk,
  input  logic                         arst_n,
  input  logic                         ord_valid,
  output logic                         ord_ready,
  input  host_wr_req_pkg::mux_user_t   ord,
  input  logic [`N_DESTS-1:0]          d_valid,
  output logic [`N_DESTS-1:0]          d_ready,
  input  host_wr_axis_pkg::axis_beat_t d_beat [`N_DESTS],
  output logic                         m_axis_valid,
  input  logic                         m_axis_ready,
  output host_wr_axis_pkg::axis_beat_t m_axis
);

  import host_wr_req_pkg::*;

  logic      head_valid;
  logic      pop;
  logic      last_beat;
  logic      xfer;
  mux_user_t head;
  len_t      cnt;

  // Order entries wait here until their data has left.
  sync_fifo #(
    .T     (mux_user_t),
    .DEPTH (`ORDER_QDEPTH)
  ) inst_ord_q (
    .aclk     (aclk),
    .arst_n   (arst_n),
    .wr_valid (ord_valid),
    .wr_ready (ord_ready),
    .wr_data  (ord),
    .rd_valid (head_valid),
    .rd_ready (pop),
    .rd_data  (head)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Beat path.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign last_beat    = (cnt == len_t'(head.len - len_t'(1)));
  assign m_axis_valid = head_valid && d_valid[head.dest];
  assign xfer         = m_axis_valid && m_axis_ready;
  assign pop          = xfer && last_beat;

  always_comb begin
    m_axis      = d_beat[head.dest];
    // The closing beat is marked from the count, not from the source.
    m_axis.last = last_beat;
  end

  // Only the selected destination sees the output ready.
  always_comb begin
    d_ready = '0;
    d_ready[head.dest] = head_valid && m_axis_ready;
  end

  // Beats of the current request sent so far.
  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      cnt <= '0;
    end else if (xfer) begin
      cnt <= last_beat ? '0 : cnt + 1'b1;
    end
  end

  // The source stream must close its request on the same beat as the count.
  assert property (@(posedge aclk) disable iff (!arst_n)
    m_axis_valid |-> (d_beat[head.dest].last == last_beat));

endmodule

`default_nettype wire

// File: verilog/dest_req_arb.sv
/*
 * Round-robin arbiter over the credited head requests.
 * Drives the registered issued request and the issue-order entry.
 */

`timescale 1ns/1ps
`default_nettype none

`include "credit_defs.svh"

module dest_req_arb (
  input  logic                      aclk,
  input  logic                      arst_n,
  input  logic [`N_DESTS-1:0]       cred_valid,
  output logic [`N_DESTS-1:0]       cred_ready,
  input  host_wr_req_pkg::req_t     cred_req [`N_DESTS],
  output logic                      m_req_valid,
  input  logic                      m_req_ready,
  output host_wr_req_pkg::req_t     m_req,
  output logic                      ord_valid,
  input  logic                      ord_ready,
  output host_wr_req_pkg::mux_user_t ord
);

  import host_wr_req_pkg::*;

  logic [`N_DESTS-1:0] grant;
  logic                can_grant;
  logic                found;
  dest_t               rr_ptr;
  dest_t               sel;

  // A grant needs room in the output register and in the order queue.
  assign can_grant = (!m_req_valid || m_req_ready) && ord_ready;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Rotating priority search.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    int idx;
    found = 1'b0;
    sel   = rr_ptr;
    // Scan from the pointer upward and wrap. The first credited destination wins.
    for (int i = 0; i < `N_DESTS; i++) begin
      idx = (int'(rr_ptr) + i) % `N_DESTS;
      if (!found && cred_valid[idx]) begin
        found = 1'b1;
        sel   = dest_t'(idx);
      end
    end
  end

  always_comb begin
    grant = '0;
    if (found && can_grant) begin
      grant[sel] = 1'b1;
    end
  end

  assign cred_ready = grant;

  // The order entry is pushed in the cycle of the grant.
  assign ord_valid = found && can_grant;
  assign ord.dest  = sel;
  assign ord.len   = cred_req[sel].len;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Issued request register.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      m_req_valid <= 1'b0;
      rr_ptr      <= '0;
    end else begin
      if (ord_valid) begin
        m_req_valid <= 1'b1;
        // Priority moves past the winner.
        rr_ptr <= dest_t'((int'(sel) + 1) % `N_DESTS);
      end else if (m_req_ready) begin
        m_req_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (ord_valid) begin
      m_req <= cred_req[sel];
    end
  end

  // A stalled issued request holds its payload until it is taken.
  assert property (@(posedge aclk) disable iff (!arst_n)
    (m_req_valid && !m_req_ready) |=> (m_req_valid && $stable(m_req)));

endmodule

`default_nettype wire

// File: verilog/dest_wr_queue.sv
/*
 * Per-destination queue.
 * Request FIFO, data FIFO and the credit counter that holds a request back
 * until all of its beats are buffered.
 */

`timescale 1ns/1ps
`default_nettype none

`include "credit_defs.svh"

module dest_wr_queue (
  input  logic                         aclk,
  input  logic                         arst_n,
  input  logic                         s_req_valid,
  output logic                         s_req_ready,
  input  host_wr_req_pkg::req_t        s_req,
  input  logic                         s_axis_valid,
  output logic                         s_axis_ready,
  input  host_wr_axis_pkg::axis_beat_t s_axis,
  output logic                         cred_valid,
  input  logic                         cred_ready,
  output host_wr_req_pkg::req_t        cred_req,
  output logic                         d_valid,
  input  logic                         d_ready,
  output host_wr_axis_pkg::axis_beat_t d_beat
);

  import host_wr_req_pkg::*;
  import host_wr_axis_pkg::*;

  logic  rq_valid;
  logic  covered;
  logic  beat_in;
  logic  issue;
  cred_t credits;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Request and data buffers.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  sync_fifo #(
    .T     (req_t),
    .DEPTH (`REQ_QDEPTH)
  ) inst_req_q (
    .aclk     (aclk),
    .arst_n   (arst_n),
    .wr_valid (s_req_valid),
    .wr_ready (s_req_ready),
    .wr_data  (s_req),
    .rd_valid (rq_valid),
    .rd_ready (issue),
    .rd_data  (cred_req)
  );

  sync_fifo #(
    .T     (axis_beat_t),
    .DEPTH (`DATA_QDEPTH)
  ) inst_data_q (
    .aclk     (aclk),
    .arst_n   (arst_n),
    .wr_valid (s_axis_valid),
    .wr_ready (s_axis_ready),
    .wr_data  (s_axis),
    .rd_valid (d_valid),
    .rd_ready (d_ready),
    .rd_data  (d_beat)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Credits.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign beat_in = s_axis_valid && s_axis_ready;

  // The head request is offered only once enough unclaimed beats sit in the data FIFO.
  assign covered    = (credits >= cred_t'(cred_req.len));
  assign cred_valid = rq_valid && covered;
  assign issue      = cred_valid && cred_ready;

  // An arriving beat and an issue in the same cycle are both applied.
  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      credits <= '0;
    end else begin
      credits <= credits + cred_t'(beat_in) - (issue ? cred_t'(cred_req.len) : cred_t'(0));
    end
  end

  // Credits count buffered beats, so they can never pass the data FIFO depth.
  assert property (@(posedge aclk) disable iff (!arst_n)
    credits <= cred_t'(`DATA_QDEPTH));

endmodule

`default_nettype wire

// File: verilog/dest_req_mux.sv
/*
 * Request router.
 * Steers each incoming request to the queue of its destination.
 */

`timescale 1ns/1ps
`default_nettype none

`include "credit_defs.svh"

module dest_req_mux (
  input  logic                   aclk,
  input  logic                   arst_n,
  input  logic                   s_req_valid,
  output logic                   s_req_ready,
  input  host_wr_req_pkg::req_t  s_req,
  output logic [`N_DESTS-1:0]    q_valid,
  input  logic [`N_DESTS-1:0]    q_ready,
  output host_wr_req_pkg::req_t  q_req
);

  // Every queue sees the same payload. Only the addressed one gets valid.
  assign q_req = s_req;

  always_comb begin
    q_valid = '0;
    q_valid[s_req.dest] = s_req_valid;
  end

  // The sender waits on the addressed queue alone.
  // A full queue for one destination therefore blocks the shared port.
  assign s_req_ready = q_ready[s_req.dest];

  // A request must name an existing destination.
  assert property (@(posedge aclk) disable iff (!arst_n)
    s_req_valid |-> (int'(s_req.dest) < `N_DESTS));

endmodule

`default_nettype wire

// File: verilog/sync_fifo.sv
/*
 * Synchronous first-word-fall-through FIFO.
 * Payload type and depth are parameters.
 */

`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
  parameter type T     = logic [7:0],
  parameter int  DEPTH = 4
) (
  input  logic aclk,
  input  logic arst_n,
  input  logic wr_valid,
  output logic wr_ready,
  input  T     wr_data,
  output logic rd_valid,
  input  logic rd_ready,
  output T     rd_data
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  T              mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [CW-1:0] count;
  logic [CW-1:0] count_nxt;
  logic          empty;
  logic          full;
  logic          wr_en;
  logic          rd_en;

  // The head entry is shown as soon as it is stored.
  assign wr_ready = !full;
  assign rd_valid = !empty;
  assign rd_data  = mem[rd_ptr];
  assign wr_en    = wr_valid && !full;
  assign rd_en    = rd_ready && !empty;

  always_comb begin
    count_nxt = count;
    if (wr_en && !rd_en) begin
      count_nxt = count + 1'b1;
    end else if (rd_en && !wr_en) begin
      count_nxt = count - 1'b1;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Pointers, count and flags.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      empty  <= 1'b1;
      full   <= 1'b0;
    end else begin
      if (wr_en) begin
        wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count_nxt;
      // Flags are taken from the next count so they stay registered.
      empty <= (count_nxt == '0);
      full  <= (count_nxt == CW'(DEPTH));
    end
  end

  always_ff @(posedge aclk) begin
    if (wr_en) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  // The registered flags must track the count, so no write lands on a full buffer.
  assert property (@(posedge aclk) disable iff (!arst_n) (count == CW'(DEPTH)) |-> !wr_en);
  // Likewise no entry is popped from an empty buffer.
  assert property (@(posedge aclk) disable iff (!arst_n) (count == '0) |-> !rd_en);

endmodule

`default_nettype wire

// File: verilog/host_wr_axis_pkg.sv
/*
 * Data stream types of the host write path.
 * One beat of data, byte keep and last.
 */

`default_nettype none

`include "credit_defs.svh"

package host_wr_axis_pkg;

  typedef logic [`DATA_BITS-1:0]   data_t;
  typedef logic [`DATA_BITS/8-1:0] keep_t;

  // A single stream beat. The last flag closes a request's data.
  typedef struct packed {
    data_t data;
    keep_t keep;
    logic  last;
  } axis_beat_t;

endpackage

`default_nettype wire

// File: verilog/host_wr_req_pkg.sv
/*
 * Request side types of the host write path.
 * Destination, length, request, order entry and credit count.
 */

`default_nettype none

`include "credit_defs.svh"

package host_wr_req_pkg;

  // Index of one destination.
  typedef logic [$clog2(`N_DESTS)-1:0] dest_t;

  // Request length in beats, from 1 up to MAX_LEN.
  typedef logic [$clog2(`MAX_LEN+1)-1:0] len_t;

  // A host write request as it arrives and as it is issued.
  typedef struct packed {
    dest_t       dest;
    len_t        len;
    logic [31:0] vaddr;
  } req_t;

  // One entry of the issue-order queue that steers the output stream.
  typedef struct packed {
    dest_t dest;
    len_t  len;
  } mux_user_t;

  // Buffered beats that no issued request has claimed, 0 to DATA_QDEPTH.
  typedef logic [$clog2(`DATA_QDEPTH+1)-1:0] cred_t;

endpackage

`default_nettype wire

// File: verilog/credit_defs.svh
/*
 * Build-time sizes of the local-credit host write path.
 * Destination count, queue depths, largest request and data width.
 */

`ifndef CREDIT_DEFS_SVH
`define CREDIT_DEFS_SVH

// Number of destinations served by the card.
`define N_DESTS 4
// Pending requests held per destination.
`define REQ_QDEPTH 4
// Buffered beats per destination. Must be at least MAX_LEN or a long request never issues.
`define DATA_QDEPTH 16
// Issued requests whose data has not fully left yet.
`define ORDER_QDEPTH 4
// Largest request length in beats.
`define MAX_LEN 8
// Width of the data streams.
`define DATA_BITS 64

`endif
